// File: logic/goldi_params.svh
/* Goldilocks modular multiplier parameters
   Side tag width and the pipeline latencies of each stage */

`ifndef GOLDI_PARAMS_SVH
`define GOLDI_PARAMS_SVH

// Width of the side tag carried next to each item
`define GOLDI_SIDE_W 8

// Inner Karatsuba multiplier: pre-add, partial products, combine
`define GOLDI_KMULT_LAT 3

// 64x64 multiplier: input reg, inner multipliers, combine reg, result reg
`define GOLDI_MULT_LAT (`GOLDI_KMULT_LAT + 3)

// Reduction: intermediate reg, residue reg
`define GOLDI_RED_LAT 2

// Whole pipeline, in to out
`define GOLDI_LAT (`GOLDI_MULT_LAT + `GOLDI_RED_LAT)

`endif

// File: logic/goldi_pkg.sv
/* Goldilocks field types
   Field element, product, side tag, the split-word union and the prime */

`include "goldi_params.svh"

package goldi_pkg;

  // One field element or raw operand
  typedef logic [63:0] goldi_elem_t;

  // Product held as two words, [1] is the upper word
  typedef logic [1:0][63:0] goldi_prod_t;

  // Side tag travelling with avail
  typedef logic [`GOLDI_SIDE_W-1:0] goldi_side_t;

  // One 64-bit word seen whole or as two 32-bit halves
  // Operand split in the multiplier, x1/x2 split in the reduction
  typedef union packed {
    logic [63:0] full;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } goldi_split_u;

  // p = 2^64 - 2^32 + 1
  localparam goldi_elem_t GOLDI_P = 64'hffff_ffff_0000_0001;

endpackage

// File: logic/karatsuba_mult.sv
/* One-level Karatsuba multiplier, z = a * b
   Three native multiplies on half-width operands, fixed 3-cycle latency */

`timescale 1ns/1ps

module karatsuba_mult #(
  parameter int OP_W = 32
) (
  input  logic              clk,
  input  logic [OP_W-1:0]   a,
  input  logic [OP_W-1:0]   b,
  output logic [2*OP_W-1:0] z
);

  // Low half takes the floor, high half any odd bit
  localparam int LO_W  = OP_W / 2;
  localparam int HI_W  = OP_W - LO_W;
  localparam int SUM_W = HI_W + 1;
  localparam int LL_W  = 2 * LO_W;
  localparam int HH_W  = 2 * HI_W;
  localparam int SS_W  = 2 * SUM_W;
  localparam int Z_W   = 2 * OP_W;

  // ----------------------------------------------------------
  // Stage 1 : split and pre-add
  // ----------------------------------------------------------
  logic [LO_W-1:0]  s1_a_lo;
  logic [LO_W-1:0]  s1_b_lo;
  logic [HI_W-1:0]  s1_a_hi;
  logic [HI_W-1:0]  s1_b_hi;
  logic [SUM_W-1:0] s1_a_sum;
  logic [SUM_W-1:0] s1_b_sum;

  always_ff @(posedge clk) begin
    s1_a_lo  <= a[LO_W-1:0];
    s1_b_lo  <= b[LO_W-1:0];
    s1_a_hi  <= a[OP_W-1:LO_W];
    s1_b_hi  <= b[OP_W-1:LO_W];
    s1_a_sum <= SUM_W'(a[LO_W-1:0]) + SUM_W'(a[OP_W-1:LO_W]);
    s1_b_sum <= SUM_W'(b[LO_W-1:0]) + SUM_W'(b[OP_W-1:LO_W]);
  end

  // ----------------------------------------------------------
  // Stage 2 : partial products
  // ----------------------------------------------------------
  logic [LL_W-1:0] s2_ll;
  logic [HH_W-1:0] s2_hh;
  logic [SS_W-1:0] s2_ss;

  always_ff @(posedge clk) begin
    s2_ll <= LL_W'(s1_a_lo) * LL_W'(s1_b_lo);
    s2_hh <= HH_W'(s1_a_hi) * HH_W'(s1_b_hi);
    s2_ss <= SS_W'(s1_a_sum) * SS_W'(s1_b_sum);
  end

  // ----------------------------------------------------------
  // Stage 3 : recombine
  // ----------------------------------------------------------
  logic [Z_W-1:0] ll_w;
  logic [Z_W-1:0] hh_w;
  logic [Z_W-1:0] mid_w;
  logic [Z_W-1:0] s3_z;

  assign ll_w  = Z_W'(s2_ll);
  assign hh_w  = Z_W'(s2_hh);
  // Cross terms a_lo*b_hi + a_hi*b_lo, never negative
  assign mid_w = Z_W'(s2_ss) - hh_w - ll_w;

  always_ff @(posedge clk) begin
    s3_z <= (hh_w << LL_W) + (mid_w << LO_W) + ll_w;
  end

  assign z = s3_z;

endmodule

// File: logic/avail_side_delay.sv
/* Avail and side tag delay line
   Shifts the valid flag and its tag through LATENCY reset stages */

`timescale 1ns/1ps

module avail_side_delay #(
  parameter int LATENCY = 8,
  parameter int SIDE_W  = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_avail,
  input  logic [SIDE_W-1:0] in_side,
  output logic              out_avail,
  output logic [SIDE_W-1:0] out_side
);

  // Stage 0 takes the input, stage LATENCY-1 drives the output
  logic [LATENCY-1:0]             avail_sr;
  logic [LATENCY-1:0][SIDE_W-1:0] side_sr;

  // ----------------------------------------------------------
  // Shift line
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      // Clear every stage, no stale avail can reach the output
      avail_sr <= '0;
      side_sr  <= '0;
    end else begin
      avail_sr[0] <= in_avail;
      side_sr[0]  <= in_side;
      for (int i = 1; i < LATENCY; i++) begin
        avail_sr[i] <= avail_sr[i-1];
        side_sr[i]  <= side_sr[i-1];
      end
    end
  end

  assign out_avail = avail_sr[LATENCY-1];
  // Tag is passed through untouched
  assign out_side  = side_sr[LATENCY-1];

endmodule

// File: logic/goldi_mult_karatsuba.sv
/* 64x64 Karatsuba multiplier for the Goldilocks field
   Three inner multipliers and a combine, 128-bit result congruent to a*b mod p */

`timescale 1ns/1ps

module goldi_mult_karatsuba (
  input  logic                  clk,
  input  goldi_pkg::goldi_elem_t a,
  input  goldi_pkg::goldi_elem_t b,
  output goldi_pkg::goldi_prod_t z
);

  import goldi_pkg::*;

  // ----------------------------------------------------------
  // S0 : input register and half sums
  // ----------------------------------------------------------
  goldi_elem_t  s0_a;
  goldi_elem_t  s0_b;
  goldi_split_u a_sp;
  goldi_split_u b_sp;
  logic [32:0]  s0_a_sum;
  logic [32:0]  s0_b_sum;

  always_ff @(posedge clk) begin
    s0_a <= a;
    s0_b <= b;
  end

  assign a_sp.full = s0_a;
  assign b_sp.full = s0_b;

  // 33-bit sums, the carry is kept
  assign s0_a_sum = {1'b0, a_sp.half.lo} + {1'b0, a_sp.half.hi};
  assign s0_b_sum = {1'b0, b_sp.half.lo} + {1'b0, b_sp.half.hi};

  // ----------------------------------------------------------
  // S1 : inner multipliers
  // ----------------------------------------------------------
  logic [63:0] s1_hh;
  logic [63:0] s1_ll;
  logic [65:0] s1_ss;
  logic [64:0] s1_sub;

  // a_hi * b_hi
  karatsuba_mult #(
    .OP_W (32)
  ) u_mult_hh (
    .clk (clk),
    .a   (a_sp.half.hi),
    .b   (b_sp.half.hi),
    .z   (s1_hh)
  );

  // a_lo * b_lo
  karatsuba_mult #(
    .OP_W (32)
  ) u_mult_ll (
    .clk (clk),
    .a   (a_sp.half.lo),
    .b   (b_sp.half.lo),
    .z   (s1_ll)
  );

  // (a_lo + a_hi) * (b_lo + b_hi)
  karatsuba_mult #(
    .OP_W (33)
  ) u_mult_ss (
    .clk (clk),
    .a   (s0_a_sum),
    .b   (s0_b_sum),
    .z   (s1_ss)
  );

  // lo*lo - hi*hi, bit 64 is the sign
  assign s1_sub = {1'b0, s1_ll} - {1'b0, s1_hh};

  // ----------------------------------------------------------
  // S2 : combine register
  // ----------------------------------------------------------
  logic [63:0]  s2_ll;
  logic [64:0]  s2_sub;
  logic [65:0]  s2_ss;
  logic [65:0]  s2_mid;
  logic [127:0] s2_mid_sh;
  logic [64:0]  s2_sub_mag;
  logic [127:0] s2_result;

  always_ff @(posedge clk) begin
    s2_ll  <= s1_ll;
    s2_sub <= s1_sub;
    s2_ss  <= s1_ss;
  end

  // hi*hi*2^64 folded as hi*hi*(2^32 - 1), so only the sum product
  // minus lo*lo is weighted by 2^32
  assign s2_mid     = s2_ss - {2'b00, s2_ll};
  assign s2_mid_sh  = {30'd0, s2_mid, 32'd0};
  // Magnitude of a negative difference
  assign s2_sub_mag = {1'b0, ~s2_sub[63:0]} + 65'd1;

  // Whole sum stays non-negative, the shifted term dominates
  assign s2_result = s2_sub[64] ? s2_mid_sh - {63'd0, s2_sub_mag}
                                : s2_mid_sh + {64'd0, s2_sub[63:0]};

  // ----------------------------------------------------------
  // S3 : result register
  // ----------------------------------------------------------
  goldi_prod_t s3_result;

  always_ff @(posedge clk) begin
    s3_result <= s2_result;
  end

  assign z = s3_result;

endmodule

// File: logic/goldi_reduce.sv
/* Goldilocks reduction, 128-bit value to canonical residue below p
   Two stages using 2^64 = 2^32 - 1 and 2^96 = -1 modulo p */

`timescale 1ns/1ps

module goldi_reduce (
  input  logic                  clk,
  input  goldi_pkg::goldi_prod_t z,
  output goldi_pkg::goldi_elem_t residue
);

  import goldi_pkg::*;

  // 2^64 mod p
  localparam goldi_elem_t EPS = 64'h0000_0000_ffff_ffff;

  // ----------------------------------------------------------
  // Stage 1 : x0 - x2 + x1*(2^32 - 1)
  // ----------------------------------------------------------
  goldi_elem_t  x0;
  goldi_split_u x_hi;
  goldi_elem_t  x1_fold;
  logic [65:0]  v_d;
  goldi_elem_t  s1_low;
  logic         s1_borrow;
  logic         s1_carry;

  assign x0        = z[0];
  // x1 in the low half, x2 in the high half
  assign x_hi.full = z[1];
  // x1*2^32 - x1, always below 2^64
  assign x1_fold   = {x_hi.half.lo, 32'd0} - {32'd0, x_hi.half.lo};

  // Range is -(2^32 - 1) up to just under 2^65, 66 bits signed
  assign v_d = {2'b00, x0} + {2'b00, x1_fold} - {34'd0, x_hi.half.hi};

  always_ff @(posedge clk) begin
    s1_low    <= v_d[63:0];
    s1_borrow <= v_d[65];
    s1_carry  <= ~v_d[65] & v_d[64];
  end

  // ----------------------------------------------------------
  // Stage 2 : fold and final subtract
  // ----------------------------------------------------------
  goldi_elem_t fold;
  goldi_elem_t fold_sub;
  goldi_elem_t s2_residue;

  always_comb begin
    if (s1_borrow) begin
      // Negative value, add p back
      fold = s1_low + GOLDI_P;
    end else if (s1_carry) begin
      // Dropped 2^64 is worth 2^32 - 1, same as subtracting p
      fold = s1_low + EPS;
    end else begin
      fold = s1_low;
    end
  end

  // Only the plain case can land at or above p
  assign fold_sub = fold - GOLDI_P;

  always_ff @(posedge clk) begin
    s2_residue <= (fold >= GOLDI_P) ? fold_sub : fold;
  end

  assign residue = s2_residue;

endmodule

// File: logic/goldi_modmul.sv
/* Pipelined Goldilocks modular multiplier, residue = a * b mod p
   Multiplier, reduction and the avail/side delay line */

`timescale 1ns/1ps

`include "goldi_params.svh"

module goldi_modmul (
  input  logic                   clk,
  input  logic                   rst,
  input  goldi_pkg::goldi_elem_t a,
  input  goldi_pkg::goldi_elem_t b,
  input  logic                   in_avail,
  input  goldi_pkg::goldi_side_t in_side,
  output goldi_pkg::goldi_elem_t residue,
  output logic                   out_avail,
  output goldi_pkg::goldi_side_t out_side
);

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  goldi_pkg::goldi_prod_t prod;

  // 6 cycles, 128-bit value congruent to a*b
  goldi_mult_karatsuba u_mult (
    .clk (clk),
    .a   (a),
    .b   (b),
    .z   (prod)
  );

  // 2 cycles, canonical residue
  goldi_reduce u_reduce (
    .clk     (clk),
    .z       (prod),
    .residue (residue)
  );

  // ----------------------------------------------------------
  // Control
  // ----------------------------------------------------------
  // Single delay line matched to the whole datapath
  avail_side_delay #(
    .LATENCY (`GOLDI_LAT),
    .SIDE_W  (`GOLDI_SIDE_W)
  ) u_delay (
    .clk       (clk),
    .rst       (rst),
    .in_avail  (in_avail),
    .in_side   (in_side),
    .out_avail (out_avail),
    .out_side  (out_side)
  );

endmodule

// File: testbench/goldi_modmul_props.sv
/* Goldilocks multiplier properties
   Avail timing after reset, avail delay and residue range */

`timescale 1ns/1ps

`include "goldi_params.svh"

module goldi_modmul_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   in_avail,
  input logic                   out_avail,
  input goldi_pkg::goldi_elem_t residue
);

  import goldi_pkg::*;

  // Cycles since the last reset edge, saturates at the latency
  int since_rst;

  always_ff @(posedge clk) begin
    if (rst) begin
      since_rst <= 0;
    end else if (since_rst < `GOLDI_LAT) begin
      since_rst <= since_rst + 1;
    end
  end

  // Delay line still flushed
  a_quiet_after_rst: assert property (@(posedge clk) disable iff (rst)
    (since_rst < `GOLDI_LAT) |-> !out_avail)
    else $error("out_avail rose within the pipeline latency after reset");

  a_avail_delay: assert property (@(posedge clk) disable iff (rst)
    (since_rst >= `GOLDI_LAT) |-> (out_avail == $past(in_avail, `GOLDI_LAT)))
    else $error("out_avail does not follow in_avail by the pipeline latency");

  // Canonical residue only
  a_residue_range: assert property (@(posedge clk) disable iff (rst)
    out_avail |-> (residue < GOLDI_P))
    else $error("residue not below p while out_avail is high");

endmodule

bind goldi_modmul goldi_modmul_props u_props (
  .clk       (clk),
  .rst       (rst),
  .in_avail  (in_avail),
  .out_avail (out_avail),
  .residue   (residue)
);

// File: testbench/goldi_modmul_tb.sv
/* Goldilocks modular multiplier testbench
   Directed table, back-to-back and gapped random items, queue-based checking */

`timescale 1ns/1ps

`include "goldi_params.svh"

module goldi_modmul_tb;

  import goldi_pkg::*;

  localparam int TBL_LEN = 13;
  localparam int N_RAND  = 200;
  // Stimulus length plus pipeline drain and some slack
  localparam int TIMEOUT = TBL_LEN + N_RAND + `GOLDI_LAT + 50;
  // p widened to the full product width for the reference model
  localparam logic [127:0] P_WIDE = {64'd0, 64'hffff_ffff_0000_0001};

  typedef struct packed {
    goldi_elem_t op_a;
    goldi_elem_t op_b;
    goldi_side_t tag;
    goldi_elem_t res;
  } vec_t;

  logic        clk = 1'b0;
  logic        rst;
  goldi_elem_t a;
  goldi_elem_t b;
  logic        in_avail;
  goldi_side_t in_side;
  goldi_elem_t residue;
  logic        out_avail;
  goldi_side_t out_side;

  vec_t        tbl [TBL_LEN];
  goldi_elem_t exp_res_q[$];
  goldi_side_t exp_side_q[$];
  int          exp_cyc_q[$];

  int cycles       = 0;
  int checks       = 0;
  int value_errors = 0;
  int other_errors = 0;
  int done_count   = 0;
  integer seed;

  goldi_modmul uut (
    .clk       (clk),
    .rst       (rst),
    .a         (a),
    .b         (b),
    .in_avail  (in_avail),
    .in_side   (in_side),
    .residue   (residue),
    .out_avail (out_avail),
    .out_side  (out_side)
  );

  always #20 clk = ~clk;

  // ----------------------------------------------------------
  // Reference model and checks
  // ----------------------------------------------------------
  // Full product, then remainder modulo p
  function automatic goldi_elem_t mulmod_ref(input goldi_elem_t x, input goldi_elem_t y);
    logic [127:0] prod;
    logic [127:0] rem;
    prod = {64'd0, x} * {64'd0, y};
    rem  = prod % P_WIDE;
    return rem[63:0];
  endfunction

  task automatic check_residue(input goldi_elem_t got, input goldi_elem_t exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Error at time %0t: %s residue %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_side(input goldi_side_t got, input goldi_side_t exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Error at time %0t: %s side tag %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    checks++;
    if (got != exp) begin
      value_errors++;
      $display("Error at time %0t: latency %0d cycles, expected %0d", $time, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // Drive helpers
  // ----------------------------------------------------------
  task automatic send_item(input goldi_elem_t op_a, input goldi_elem_t op_b,
                           input goldi_side_t tag, input goldi_elem_t res);
    @(posedge clk);
    #2;
    a        = op_a;
    b        = op_b;
    in_side  = tag;
    in_avail = 1'b1;
    exp_res_q.push_back(res);
    exp_side_q.push_back(tag);
    // Edge at which the DUT samples this item
    exp_cyc_q.push_back(cycles + 1);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    in_avail = 1'b0;
  endtask

  // Cycle counter and run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT);
      $display("Checks: %0d, value errors: %0d, other errors: %0d",
               checks, value_errors, other_errors);
      $display("Errors found");
      $finish;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (out_avail) begin
        if (exp_res_q.size() == 0) begin
          other_errors++;
          $display("Output marked available at time %0t with no item in flight", $time);
        end else begin
          check_residue(residue, exp_res_q.pop_front(), "item");
          check_side(out_side, exp_side_q.pop_front(), "item");
          // Result is taken at the coming edge
          check_latency(cycles + 1 - exp_cyc_q.pop_front(), `GOLDI_LAT);
          done_count++;
        end
      end else if (done_count == 0) begin
        // Nothing has completed yet, tag must stay cleared
        check_side(out_side, '0, "idle after reset");
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    goldi_elem_t op_a;
    goldi_elem_t op_b;
    goldi_side_t tag;
    int          gap;
    int          gap_budget;

    seed     = 32'h52a04365;
    rst      = 1'b1;
    a        = '0;
    b        = '0;
    in_avail = 1'b0;
    in_side  = '0;
    gap_budget = 30;

    // Identities and operands at or above p
    tbl[0]  = '{64'h0, 64'h1234, 8'h10, 64'h0};
    tbl[1]  = '{64'h1234_5678_9abc_def0, 64'h0, 8'h11, 64'h0};
    tbl[2]  = '{64'h1, 64'h1234_5678_9abc_def0, 8'h12, 64'h1234_5678_9abc_def0};
    tbl[3]  = '{64'h1, 64'hffff_ffff_0000_0001, 8'h13, 64'h0};
    tbl[4]  = '{64'h1, 64'hffff_ffff_ffff_ffff, 8'h14, 64'h0000_0000_ffff_fffe};
    tbl[5]  = '{64'hffff_ffff_0000_0000, 64'hffff_ffff_0000_0000, 8'h15, 64'h1};
    tbl[6]  = '{64'h1_0000_0000, 64'h1_0000_0000, 8'h16, 64'h0000_0000_ffff_ffff};
    tbl[7]  = '{64'h8000_0000_0000_0000, 64'h2, 8'h17, 64'h0000_0000_ffff_ffff};
    tbl[8]  = '{64'hffff_ffff_0000_0000, 64'h2, 8'h18, 64'hffff_fffe_ffff_ffff};
    tbl[9]  = '{64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 8'h19,
                64'hffff_fffc_0000_0004};
    tbl[10] = '{64'hffff_ffff_0000_0001, 64'hffff_ffff_0000_0001, 8'h1a, 64'h0};
    tbl[11] = '{64'hffff_ffff_0000_0002, 64'hffff_ffff_0000_0002, 8'h1b, 64'h1};
    tbl[12] = '{64'hffff_ffff_ffff_ffff, 64'hffff_ffff_0000_0000, 8'h1c,
                64'hffff_fffe_0000_0003};

    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    for (int i = 0; i < TBL_LEN; i++) begin
      send_item(tbl[i].op_a, tbl[i].op_b, tbl[i].tag, tbl[i].res);
    end

    // First half back to back, second half with random gaps
    for (int i = 0; i < N_RAND; i++) begin
      op_a = {$random(seed), $random(seed)};
      op_b = {$random(seed), $random(seed)};
      tag  = goldi_side_t'($random(seed));
      // Push some operands into the top range, near or above p
      if (i % 10 == 3) begin
        op_a = op_a | 64'hffff_ffff_0000_0000;
      end
      if (i % 10 == 7) begin
        op_b = op_b | 64'hffff_ffff_0000_0000;
      end
      if (i >= N_RAND / 2) begin
        gap = $unsigned($random(seed)) % 3;
        while (gap > 0 && gap_budget > 0) begin
          idle_cycle();
          gap--;
          gap_budget--;
        end
      end
      send_item(op_a, op_b, tag, mulmod_ref(op_a, op_b));
    end
    idle_cycle();

    // Last item leaves after the pipeline latency
    repeat (`GOLDI_LAT + 2) @(negedge clk);
    if (exp_res_q.size() != 0) begin
      other_errors++;
      $display("%0d expected results never came out of the pipeline", exp_res_q.size());
    end

    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/goldi_pkg.sv
logic/karatsuba_mult.sv
logic/avail_side_delay.sv
logic/goldi_mult_karatsuba.sv
logic/goldi_reduce.sv
logic/goldi_modmul.sv
testbench/goldi_modmul_props.sv
testbench/goldi_modmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Goldilocks multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module goldi_modmul_tb -f vlog.f -o goldi_sim

if ! ./obj_dir/goldi_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation aborted"
  exit 1
fi
cat sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
exit 0
